// File: common/hbm_rd_pkg.sv
package hbm_rd_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths and sizes
    ////////////////////////////////////////////////////////////////////////////

    localparam int CHAN_DATA_W   = 256;     // one pseudo-channel beat
    localparam int ENGINE_DATA_W = 512;     // one engine word, two beats
    localparam int NUM_CHAN      = 2;       // channel pair per engine
    localparam int HBM_ADDR_W    = 33;      // 8G byte space
    localparam int STRIDE_W      = 32;      // byte step between bursts
    localparam int NBITS_W       = 8;       // bit plane count
    localparam int DIM_W         = 16;      // 8-beat blocks per plane
    localparam int CNT_W         = 24;      // burst and beat counters

    localparam int BURST_BEATS   = 8;       // beats per read burst
    localparam int BEAT_BYTES    = 32;      // 256 bits

    // channel 1 region sits this far above channel 0
    localparam logic [HBM_ADDR_W-1:0] CHAN_SPAN = 33'h0_0800_0000;

    localparam int FIFO_DEPTH    = 16;
    localparam int FIFO_PTR_W    = $clog2(FIFO_DEPTH);
    localparam int FIFO_AFULL    = 8;       // half full, one burst of slack

    localparam int RD_MAX_OUTST  = 4;       // bursts in flight per channel
    localparam int OUTST_W       = 3;       // holds 0..RD_MAX_OUTST

    ////////////////////////////////////////////////////////////////////////////
    // bundles
    ////////////////////////////////////////////////////////////////////////////

    // job parameters, latched once per start edge
    typedef struct packed {
        logic [HBM_ADDR_W-1:0] base_addr;
        logic [STRIDE_W-1:0]   stride;
        logic [CNT_W-1:0]      num_bursts;  // per channel
        logic [CNT_W-1:0]      num_beats;   // num_bursts * BURST_BEATS
    } job_cfg_t;

    // read address request
    typedef struct packed {
        logic [HBM_ADDR_W-1:0] addr;
        logic [7:0]            len;         // beats - 1
    } ar_req_t;

    // read data beat
    typedef struct packed {
        logic [CHAN_DATA_W-1:0] data;
        logic                   last;
    } r_beat_t;

    // engine word, filled as two channel halves, consumed as one bus
    typedef union packed {
        logic [ENGINE_DATA_W-1:0]          raw;
        logic [1:0][CHAN_DATA_W-1:0]       half;  // [0] chan 0, [1] chan 1
    } engine_word_u;

endpackage

// File: source/job_decode.sv
`timescale 1ns/1ps

module job_decode import hbm_rd_pkg::*; (
    input  logic                  hbm_clk,
    input  logic                  hbm_rstn,

    input  logic                  start_i,           // level from software
    input  logic [HBM_ADDR_W-1:0] base_addr_i,
    input  logic [STRIDE_W-1:0]   stride_i,
    input  logic [NBITS_W-1:0]    number_of_bits_i,
    input  logic [DIM_W-1:0]      dim_blocks_i,

    input  logic                  job_done_i,        // from pair merger
    output job_cfg_t              cfg_o,
    output logic                  launch_o,          // one cycle
    output logic                  busy_o
);

    logic             start_d1;
    logic             start_d2;
    logic             start_rise;
    logic             fire;
    logic [CNT_W-1:0] bursts;

    ////////////////////////////////////////////////////////////////////////////
    // start edge
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            start_d1 <= 1'b0;
            start_d2 <= 1'b0;
        end else begin
            start_d1 <= start_i;
            start_d2 <= start_d1;
        end
    end

    assign start_rise = start_d1 & ~start_d2;   // low-to-high only
    assign fire       = start_rise & ~busy_o;   // edges during a job dropped

    // 8 x 16 bit product fits the 24 bit counter exactly
    assign bursts = number_of_bits_i * dim_blocks_i;

    ////////////////////////////////////////////////////////////////////////////
    // launch and busy
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            launch_o <= 1'b0;
            busy_o   <= 1'b0;
        end else begin
            launch_o <= fire;
            if (fire) begin
                busy_o <= 1'b1;             // high from the launch cycle on
            end else if (job_done_i) begin
                busy_o <= 1'b0;
            end
        end
    end

    // parameters held until the next accepted edge
    always_ff @(posedge hbm_clk) begin
        if (fire) begin
            cfg_o.base_addr  <= base_addr_i;
            cfg_o.stride     <= stride_i;
            cfg_o.num_bursts <= bursts;
            cfg_o.num_beats  <= CNT_W'(bursts * BURST_BEATS);
        end
    end

endmodule

// File: reader/chan_reader.sv
`timescale 1ns/1ps

module chan_reader import hbm_rd_pkg::*; #(
    parameter int CHAN_ID = 0                    // selects channel region
) (
    input  logic                   hbm_clk,
    input  logic                   hbm_rstn,

    input  job_cfg_t               cfg_i,
    input  logic                   launch_i,

    // read address
    output ar_req_t                ar_o,
    output logic                   ar_valid_o,
    input  logic                   ar_ready_i,

    // read data
    input  r_beat_t                r_i,
    input  logic                   r_valid_i,
    output logic                   r_ready_o,

    // toward the channel fifo
    input  logic                   fifo_afull_i,
    output logic                   push_o,
    output logic [CHAN_DATA_W-1:0] push_beat_o
);

    logic                  active;          // bursts still to issue
    logic [CNT_W-1:0]      burst_cnt;
    logic [HBM_ADDR_W-1:0] ar_addr;
    logic [OUTST_W-1:0]    outst;           // issued, last beat not back yet
    logic                  ar_fire;
    logic                  r_fire;
    logic                  burst_end;

    ////////////////////////////////////////////////////////////////////////////
    // address phase
    ////////////////////////////////////////////////////////////////////////////

    // outst only drops while valid is up, so valid holds until the handshake
    assign ar_valid_o = active & (outst < OUTST_W'(RD_MAX_OUTST));
    assign ar_fire    = ar_valid_o & ar_ready_i;

    assign ar_o.addr  = ar_addr;
    assign ar_o.len   = 8'(BURST_BEATS - 1);    // always 8 beats

    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            active    <= 1'b0;
            burst_cnt <= '0;
        end else if (launch_i) begin
            active    <= (cfg_i.num_bursts != '0);
            burst_cnt <= '0;
        end else if (ar_fire) begin
            burst_cnt <= burst_cnt + CNT_W'(1);
            if (burst_cnt == cfg_i.num_bursts - CNT_W'(1)) begin
                active <= 1'b0;             // final request accepted
            end
        end
    end

    // strided walk from the channel base
    always_ff @(posedge hbm_clk) begin
        if (launch_i) begin
            ar_addr <= cfg_i.base_addr + HBM_ADDR_W'(CHAN_ID) * CHAN_SPAN;
        end else if (ar_fire) begin
            ar_addr <= ar_addr + HBM_ADDR_W'(cfg_i.stride);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // data phase
    ////////////////////////////////////////////////////////////////////////////

    assign r_ready_o   = ~fifo_afull_i;         // back-pressure from fifo
    assign r_fire      = r_valid_i & r_ready_o;
    assign burst_end   = r_fire & r_i.last;

    assign push_o      = r_fire;
    assign push_beat_o = r_i.data;

    // bursts in flight
    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            outst <= '0;
        end else begin
            case ({ar_fire, burst_end})
                2'b10:   outst <= outst + OUTST_W'(1);
                2'b01:   outst <= outst - OUTST_W'(1);
                default: outst <= outst;    // none or both
            endcase
        end
    end

endmodule

// File: reader/chan_fifo.sv
`timescale 1ns/1ps

module chan_fifo import hbm_rd_pkg::*; (
    input  logic                   hbm_clk,
    input  logic                   hbm_rstn,

    input  logic                   push_i,
    input  logic [CHAN_DATA_W-1:0] push_beat_i,

    input  logic                   pop_i,
    output logic [CHAN_DATA_W-1:0] pop_beat_o,      // head, shown ahead of pop
    output logic                   empty_o,
    output logic                   afull_o
);

    logic [CHAN_DATA_W-1:0] mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0]  wr_ptr;
    logic [FIFO_PTR_W-1:0]  rd_ptr;
    logic [FIFO_PTR_W:0]    count;              // 0..FIFO_DEPTH
    logic                   do_push;
    logic                   do_pop;

    assign do_push    = push_i & (count != (FIFO_PTR_W+1)'(FIFO_DEPTH));
    assign do_pop     = pop_i & ~empty_o;

    assign empty_o    = (count == '0);
    assign afull_o    = (count >= (FIFO_PTR_W+1)'(FIFO_AFULL));
    assign pop_beat_o = mem[rd_ptr];

    // storage
    always_ff @(posedge hbm_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_beat_i;
        end
    end

    // pointers wrap on power-of-two depth
    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + FIFO_PTR_W'(1);
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + FIFO_PTR_W'(1);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + (FIFO_PTR_W+1)'(1);
                2'b01:   count <= count - (FIFO_PTR_W+1)'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

// File: source/pair_merge.sv
`timescale 1ns/1ps

module pair_merge import hbm_rd_pkg::*; (
    input  logic                   hbm_clk,
    input  logic                   hbm_rstn,

    input  job_cfg_t               cfg_i,
    input  logic                   launch_i,

    // channel fifo heads
    input  logic [CHAN_DATA_W-1:0] beat0_i,
    input  logic [CHAN_DATA_W-1:0] beat1_i,
    input  logic                   empty0_i,
    input  logic                   empty1_i,
    output logic                   pop_o,           // pops both fifos

    // engine side
    output engine_word_u           engine_data_o,
    output logic                   engine_valid_o,
    input  logic                   engine_afull_i,

    output logic                   job_done_o       // one cycle
);

    logic             afull_q;
    logic [CNT_W-1:0] word_cnt;
    logic             last_word;

    ////////////////////////////////////////////////////////////////////////////
    // pop and word forming
    ////////////////////////////////////////////////////////////////////////////

    // both halves present and engine not near full
    assign pop_o = ~empty0_i & ~empty1_i & ~afull_q;

    always_ff @(posedge hbm_clk) begin
        if (pop_o) begin
            engine_data_o.half[0] <= beat0_i;   // chan 0 low half
            engine_data_o.half[1] <= beat1_i;   // chan 1 high half
        end
    end

    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            afull_q        <= 1'b0;
            engine_valid_o <= 1'b0;
        end else begin
            afull_q        <= engine_afull_i;   // at most two words after rise
            engine_valid_o <= pop_o;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // job end
    ////////////////////////////////////////////////////////////////////////////

    assign last_word = engine_valid_o & (word_cnt == cfg_i.num_beats - CNT_W'(1));

    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            word_cnt   <= '0;
            job_done_o <= 1'b0;
        end else begin
            if (launch_i) begin
                word_cnt <= '0;             // new job
            end else if (engine_valid_o) begin
                word_cnt <= word_cnt + CNT_W'(1);
            end
            job_done_o <= last_word;        // cycle after final word
        end
    end

endmodule

// File: source/hbm_read_top.sv
`timescale 1ns/1ps

module hbm_read_top import hbm_rd_pkg::*; (
    input  logic                  hbm_clk,
    input  logic                  hbm_rstn,

    // job parameters
    input  logic                  start_i,
    input  logic [HBM_ADDR_W-1:0] base_addr_i,
    input  logic [STRIDE_W-1:0]   stride_i,
    input  logic [NBITS_W-1:0]    number_of_bits_i,
    input  logic [DIM_W-1:0]      dim_blocks_i,

    // hbm read ports, one per pseudo-channel
    output ar_req_t               ar_o       [NUM_CHAN],
    output logic                  ar_valid_o [NUM_CHAN],
    input  logic                  ar_ready_i [NUM_CHAN],
    input  r_beat_t               r_i        [NUM_CHAN],
    input  logic                  r_valid_i  [NUM_CHAN],
    output logic                  r_ready_o  [NUM_CHAN],

    // compute engine
    output engine_word_u          engine_data_o,
    output logic                  engine_valid_o,
    input  logic                  engine_afull_i,

    output logic                  busy_o,
    output logic                  job_done_o
);

    job_cfg_t               cfg;
    logic                   launch;
    logic                   push      [NUM_CHAN];
    logic [CHAN_DATA_W-1:0] push_beat [NUM_CHAN];
    logic [CHAN_DATA_W-1:0] pop_beat  [NUM_CHAN];
    logic                   empty     [NUM_CHAN];
    logic                   afull     [NUM_CHAN];
    logic                   pop;                    // shared by both fifos

    ////////////////////////////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////////////////////////////

    job_decode u_job_decode (
        .hbm_clk          (hbm_clk),
        .hbm_rstn         (hbm_rstn),
        .start_i          (start_i),
        .base_addr_i      (base_addr_i),
        .stride_i         (stride_i),
        .number_of_bits_i (number_of_bits_i),
        .dim_blocks_i     (dim_blocks_i),
        .job_done_i       (job_done_o),     // loops back from merger
        .cfg_o            (cfg),
        .launch_o         (launch),
        .busy_o           (busy_o)
    );

    ////////////////////////////////////////////////////////////////////////////
    // per-channel reader and fifo
    ////////////////////////////////////////////////////////////////////////////

    for (genvar c = 0; c < NUM_CHAN; c++) begin : g_chan
        chan_reader #(
            .CHAN_ID (c)
        ) u_reader (
            .hbm_clk      (hbm_clk),
            .hbm_rstn     (hbm_rstn),
            .cfg_i        (cfg),
            .launch_i     (launch),
            .ar_o         (ar_o[c]),
            .ar_valid_o   (ar_valid_o[c]),
            .ar_ready_i   (ar_ready_i[c]),
            .r_i          (r_i[c]),
            .r_valid_i    (r_valid_i[c]),
            .r_ready_o    (r_ready_o[c]),
            .fifo_afull_i (afull[c]),
            .push_o       (push[c]),
            .push_beat_o  (push_beat[c])
        );

        chan_fifo u_fifo (
            .hbm_clk     (hbm_clk),
            .hbm_rstn    (hbm_rstn),
            .push_i      (push[c]),
            .push_beat_i (push_beat[c]),
            .pop_i       (pop),
            .pop_beat_o  (pop_beat[c]),
            .empty_o     (empty[c]),
            .afull_o     (afull[c])
        );
    end

    ////////////////////////////////////////////////////////////////////////////
    // merge toward the engine
    ////////////////////////////////////////////////////////////////////////////

    pair_merge u_pair_merge (
        .hbm_clk        (hbm_clk),
        .hbm_rstn       (hbm_rstn),
        .cfg_i          (cfg),
        .launch_i       (launch),
        .beat0_i        (pop_beat[0]),
        .beat1_i        (pop_beat[1]),
        .empty0_i       (empty[0]),
        .empty1_i       (empty[1]),
        .pop_o          (pop),
        .engine_data_o  (engine_data_o),
        .engine_valid_o (engine_valid_o),
        .engine_afull_i (engine_afull_i),
        .job_done_o     (job_done_o)
    );

endmodule

// File: tb/hbm_mem_model.sv
`timescale 1ns/1ps

module hbm_mem_model import hbm_rd_pkg::*; (
    input  logic    hbm_clk,
    input  logic    hbm_rstn,
    input  int      stall_pct_i,                    // stall chance in percent
    input  ar_req_t ar_i       [NUM_CHAN],
    input  logic    ar_valid_i [NUM_CHAN],
    output logic    ar_ready_o [NUM_CHAN],
    output r_beat_t r_o        [NUM_CHAN],
    output logic    r_valid_o  [NUM_CHAN],
    input  logic    r_ready_i  [NUM_CHAN]
);

    localparam int QUEUE_DEPTH = 8;

    integer                seed = 11;
    logic [HBM_ADDR_W-1:0] pend [NUM_CHAN][QUEUE_DEPTH];   // accepted burst addresses
    int                    wr_idx   [NUM_CHAN];
    int                    rd_idx   [NUM_CHAN];
    int                    pend_cnt [NUM_CHAN];
    int                    beat     [NUM_CHAN];          // next beat of head burst
    logic                  r_taken  [NUM_CHAN];

    // eight copies of the beat address, bit 31 holds the channel
    function automatic logic [CHAN_DATA_W-1:0] fill_beat(input logic [HBM_ADDR_W-1:0] addr,
                                                         input int j, input int c);
        logic [31:0] word;
        word     = 32'(addr + HBM_ADDR_W'(j * BEAT_BYTES));
        word[31] = (c != 0);
        return {8{word}};
    endfunction

    function automatic logic roll_stall();
        return int'($unsigned($random(seed)) % 100) < stall_pct_i;
    endfunction

    initial begin
        for (int c = 0; c < NUM_CHAN; c++) begin
            ar_ready_o[c] = 1'b0;
            r_valid_o[c]  = 1'b0;
            r_o[c]        = '0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // handshakes seen at the rising edge
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge hbm_clk) begin
        for (int c = 0; c < NUM_CHAN; c++) begin
            r_taken[c] = 1'b0;
            if (hbm_rstn && ar_valid_i[c] && ar_ready_o[c]) begin
                pend[c][wr_idx[c]] = ar_i[c].addr;
                wr_idx[c]          = (wr_idx[c] + 1) % QUEUE_DEPTH;
                pend_cnt[c]++;
            end
            if (hbm_rstn && r_valid_o[c] && r_ready_i[c]) begin
                r_taken[c] = 1'b1;
                if (beat[c] == BURST_BEATS - 1) begin   // burst complete
                    beat[c]   = 0;
                    rd_idx[c] = (rd_idx[c] + 1) % QUEUE_DEPTH;
                    pend_cnt[c]--;
                end else begin
                    beat[c]++;
                end
            end
        end
    end

    // new ready and data on the falling edge
    always @(negedge hbm_clk) begin
        for (int c = 0; c < NUM_CHAN; c++) begin
            if (!hbm_rstn) begin
                ar_ready_o[c] = 1'b0;
                r_valid_o[c]  = 1'b0;
                wr_idx[c]     = 0;
                rd_idx[c]     = 0;
                pend_cnt[c]   = 0;
                beat[c]       = 0;
            end else begin
                ar_ready_o[c] = (pend_cnt[c] < QUEUE_DEPTH) && !roll_stall();
                if (!r_valid_o[c] || r_taken[c]) begin  // offered beat held until taken
                    r_valid_o[c]  = (pend_cnt[c] != 0) && !roll_stall();
                    r_o[c].data   = fill_beat(pend[c][rd_idx[c]], beat[c], c);
                    r_o[c].last   = (beat[c] == BURST_BEATS - 1);
                end
            end
        end
    end

endmodule

// File: tb/tb_hbm_read_top.sv
`timescale 1ns/1ps

module tb_hbm_read_top import hbm_rd_pkg::*; ();

    localparam int NUM_TESTS   = 4;
    localparam int HOLD_CYCLES = 6;

    // one job per row
    typedef struct packed {
        logic [HBM_ADDR_W-1:0] base;
        logic [STRIDE_W-1:0]   stride;
        logic [NBITS_W-1:0]    nbits;
        logic [DIM_W-1:0]      dim;
        logic [7:0]            stall_pct;       // memory stall chance
        logic [7:0]            afull_pct;       // engine almost-full chance
        logic [CNT_W-1:0]      exp_words;       // nbits * dim * 8
    } test_row_t;

    test_row_t tests [NUM_TESTS] = '{
        '{33'h0_0000_1000, 32'h0000_0100, 8'd1, 16'd1, 8'd0,  8'd0,  24'd8},
        '{33'h1_2000_0000, 32'h0000_0400, 8'd2, 16'd3, 8'd30, 8'd0,  24'd48},
        '{33'h0_4000_0040, 32'h0000_0100, 8'd3, 16'd2, 8'd0,  8'd40, 24'd48},
        '{33'h0_7fff_ff00, 32'h0000_1000, 8'd4, 16'd4, 8'd40, 8'd50, 24'd128}
    };
    string names [NUM_TESTS] = '{"one_block", "mem_stall", "engine_afull", "both_press"};

    logic                  hbm_clk = 1'b0;
    logic                  hbm_rstn;
    logic                  start;
    logic [HBM_ADDR_W-1:0] base_addr;
    logic [STRIDE_W-1:0]   stride;
    logic [NBITS_W-1:0]    nbits;
    logic [DIM_W-1:0]      dim;
    ar_req_t               ar       [NUM_CHAN];
    logic                  ar_valid [NUM_CHAN];
    logic                  ar_ready [NUM_CHAN];
    r_beat_t               r        [NUM_CHAN];
    logic                  r_valid  [NUM_CHAN];
    logic                  r_ready  [NUM_CHAN];
    engine_word_u          engine_data;
    engine_word_u          exp_word;
    logic                  engine_valid;
    logic                  engine_afull;
    logic                  busy;
    logic                  job_done;

    test_row_t cur;                             // row being run
    string     cur_name;
    integer    seed = 11;
    int        cycles, limit, checks, errors;
    int        word_cnt, done_cnt, afull_words, relaunch;
    int        ar_cnt [NUM_CHAN];

    initial begin
        forever #50 hbm_clk = ~hbm_clk;         // 100 ns period
    end

    hbm_read_top DUT (
        .hbm_clk (hbm_clk), .hbm_rstn (hbm_rstn), .start_i (start),
        .base_addr_i (base_addr), .stride_i (stride),
        .number_of_bits_i (nbits), .dim_blocks_i (dim),
        .ar_o (ar), .ar_valid_o (ar_valid), .ar_ready_i (ar_ready),
        .r_i (r), .r_valid_i (r_valid), .r_ready_o (r_ready),
        .engine_data_o (engine_data), .engine_valid_o (engine_valid),
        .engine_afull_i (engine_afull), .busy_o (busy), .job_done_o (job_done)
    );

    hbm_mem_model u_mem (
        .hbm_clk (hbm_clk), .hbm_rstn (hbm_rstn), .stall_pct_i (int'(cur.stall_pct)),
        .ar_i (ar), .ar_valid_i (ar_valid), .ar_ready_o (ar_ready),
        .r_o (r), .r_valid_o (r_valid), .r_ready_i (r_ready)
    );

    function automatic logic [HBM_ADDR_W-1:0] burst_addr(input int c, input int k);
        return cur.base + (c != 0 ? CHAN_SPAN : '0) + HBM_ADDR_W'(k) * HBM_ADDR_W'(cur.stride);
    endfunction

    // low 31 address bits of the beat, channel on top, eight times over
    function automatic logic [CHAN_DATA_W-1:0] beat_pattern(input logic [HBM_ADDR_W-1:0] addr,
                                                            input int j, input int c);
        logic [31:0] word;
        word = {c[0], 31'(addr[30:0] + 31'(j * BEAT_BYTES))};
        return {8{word}};
    endfunction

    task automatic compare_value(input string name, input logic [ENGINE_DATA_W-1:0] exp_val,
                                 input logic [ENGINE_DATA_W-1:0] act_val);
        checks++;
        if (exp_val !== act_val) begin
            errors++;
            $display("[FAIL] %s expected %0h actual %0h", name, exp_val, act_val);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // engine back-pressure and monitors
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge hbm_clk) begin
        engine_afull = hbm_rstn && (int'($unsigned($random(seed)) % 100) < int'(cur.afull_pct));
    end

    always @(posedge hbm_clk) begin
        for (int c = 0; c < NUM_CHAN; c++) begin
            if (ar_valid[c] && ar_ready[c]) begin
                compare_value({cur_name, " ar_addr"}, burst_addr(c, ar_cnt[c]), ar[c].addr);
                compare_value({cur_name, " ar_len"}, BURST_BEATS - 1, ar[c].len);
                ar_cnt[c]++;
            end
        end
        if (engine_valid) begin                 // word n = beat n of each channel
            exp_word.half[0] = beat_pattern(burst_addr(0, word_cnt / BURST_BEATS),
                                            word_cnt % BURST_BEATS, 0);
            exp_word.half[1] = beat_pattern(burst_addr(1, word_cnt / BURST_BEATS),
                                            word_cnt % BURST_BEATS, 1);
            compare_value({cur_name, " engine_word"}, exp_word.raw, engine_data.raw);
            word_cnt++;
        end
        if (job_done) done_cnt++;
        if (!engine_afull) begin
            afull_words = 0;
        end else if (engine_valid) begin        // words since afull went up
            afull_words++;
            if (afull_words > 2) compare_value({cur_name, " afull_overrun"}, 2, afull_words);
        end
    end

    initial begin
        @(posedge hbm_clk);
        while (cycles < limit) begin
            @(posedge hbm_clk);
            cycles++;
        end
        $display("run timed out after %0d cycles with no end of test", limit);
        $display("checks %0d errors %0d", checks, errors);
        $display("tests failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        hbm_rstn     = 1'b0;
        start        = 1'b0;
        base_addr    = '0;
        stride       = '0;
        nbits        = '0;
        dim          = '0;
        engine_afull = 1'b0;
        cur          = '0;
        cur_name     = "reset_idle";
        limit        = 200;
        for (int t = 0; t < NUM_TESTS; t++) limit += 40 * int'(tests[t].exp_words);
        repeat (10) @(negedge hbm_clk);
        hbm_rstn = 1'b1;
        repeat (4) begin                        // quiet until the first start
            @(negedge hbm_clk);
            compare_value("reset_idle ar_valid", 0, {ar_valid[1], ar_valid[0]});
            compare_value("reset_idle r_ready", 2'b11, {r_ready[1], r_ready[0]});
            compare_value("reset_idle flags", 0, {engine_valid, job_done, busy});
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            @(posedge hbm_clk);                 // DUT idle between jobs
            cur       = tests[t];
            cur_name  = names[t];
            ar_cnt[0] = 0;
            ar_cnt[1] = 0;
            word_cnt  = 0;
            done_cnt  = 0;
            @(negedge hbm_clk);
            base_addr = cur.base;
            stride    = cur.stride;
            nbits     = cur.nbits;
            dim       = cur.dim;
            start     = 1'b1;
            repeat (2) @(negedge hbm_clk);
            compare_value({cur_name, " launch"}, 1, busy);
            start = 1'b0;                       // second edge while busy
            repeat (2) @(negedge hbm_clk);
            start = 1'b1;
            while (!job_done) @(negedge hbm_clk);
            compare_value({cur_name, " words_at_done"}, cur.exp_words, word_cnt);
            @(negedge hbm_clk);
            compare_value({cur_name, " busy_end"}, 0, busy);
            relaunch = 0;
            repeat (HOLD_CYCLES) begin          // start still held high
                @(negedge hbm_clk);
                if (busy || ar_valid[0] || ar_valid[1]) relaunch++;
            end
            compare_value({cur_name, " relaunch"}, 0, relaunch);
            compare_value({cur_name, " done_count"}, 1, done_cnt);
            compare_value({cur_name, " words"}, cur.exp_words, word_cnt);
            compare_value({cur_name, " ar_count0"}, cur.nbits * cur.dim, ar_cnt[0]);
            compare_value({cur_name, " ar_count1"}, cur.nbits * cur.dim, ar_cnt[1]);
            start = 1'b0;
            repeat (3) @(negedge hbm_clk);
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
common/hbm_rd_pkg.sv
source/job_decode.sv
reader/chan_reader.sv
reader/chan_fifo.sv
source/pair_merge.sv
source/hbm_read_top.sv
tb/hbm_mem_model.sv
tb/tb_hbm_read_top.sv

// File: Bender.yml
package:
  name: hbm_read

sources:
  - common/hbm_rd_pkg.sv
  - source/job_decode.sv
  - reader/chan_reader.sv
  - reader/chan_fifo.sv
  - source/pair_merge.sv
  - source/hbm_read_top.sv
  - target: test
    files:
      - tb/hbm_mem_model.sv
      - tb/tb_hbm_read_top.sv
